/* design/llc_pkg.sv */
`default_nettype none

package llc_pkg;

    // slice geometry
    localparam int LLC_WAYS           = 4;
    localparam int LLC_WAY_BITS       = $clog2(LLC_WAYS);
    localparam int LLC_SET_BITS       = 6;
    localparam int LLC_BANK_BITS      = 1;
    localparam int LLC_BANKS          = 1 << LLC_BANK_BITS;
    localparam int LLC_BANK_ADDR_BITS = LLC_SET_BITS - LLC_BANK_BITS;
    localparam int LLC_BANK_DEPTH     = 1 << LLC_BANK_ADDR_BITS;

    // field widths
    localparam int LLC_LINE_BITS    = 64;
    localparam int LLC_TAG_BITS     = 12;
    localparam int LLC_SHARERS_BITS = 4;
    localparam int LLC_OWNER_BITS   = 2;
    localparam int LLC_STATE_BITS   = 3;

    typedef logic [LLC_SET_BITS-1:0]       llc_set_t;
    typedef logic [LLC_WAY_BITS-1:0]       llc_way_t;
    typedef logic [LLC_BANK_BITS-1:0]      llc_bank_t;
    typedef logic [LLC_BANK_ADDR_BITS-1:0] llc_bank_addr_t;

    typedef logic [LLC_LINE_BITS-1:0]    line_t;
    typedef logic [LLC_TAG_BITS-1:0]     llc_tag_t;
    typedef logic [LLC_SHARERS_BITS-1:0] sharers_t;
    typedef logic [LLC_OWNER_BITS-1:0]   owner_t;
    typedef logic                        hprot_t;
    typedef logic [LLC_STATE_BITS-1:0]   llc_state_t;

    // coherence part, the only part a flush rewrites
    typedef struct packed {
        llc_state_t state;
        sharers_t   sharers;
        logic       dirty;
    } llc_coh_t;

    // data part of one way
    typedef struct packed {
        llc_tag_t tag;
        owner_t   owner;
        hprot_t   hprot;
        line_t    line;
    } llc_data_t;

    // per-way write strobes for the two groups
    typedef struct packed {
        logic coh;
        logic data;
    } llc_wr_en_t;

endpackage

`default_nettype wire

/* design/llc_bank_ram.sv */
`timescale 1ns/1ns
`default_nettype none

module llc_bank_ram #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 32
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  logic                     en,
    input  logic                     we,
    input  logic [WIDTH-1:0]         wdata,
    output logic [WIDTH-1:0]         rdata
);

    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // read-first so a write on the same edge shows up on the next read
    always_ff @(posedge clk) begin
        if (rst) begin
            rdata <= '0;
        end else if (en) begin
            rdata <= mem[addr];
        end
    end

    addr_known_a: assert property (@(posedge clk) disable iff (rst)
        (en || we) |-> !$isunknown(addr));

endmodule

`default_nettype wire

/* design/llc_wr_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module llc_wr_ctrl
    import llc_pkg::*;
(
    input  logic                         wr_en,
    input  llc_way_t                     way,
    input  logic [LLC_WAYS-1:0]          wr_rst_flush,
    output llc_wr_en_t [LLC_WAYS-1:0]    way_wr_en
);

    logic [LLC_WAYS-1:0] way_hit;

    // request decode, one way at most
    always_comb begin
        for (int i = 0; i < LLC_WAYS; i++) begin
            way_hit[i] = wr_en && (way == llc_way_t'(i));
        end
    end

    // flush reaches the coherence group of every flagged way
    always_comb begin
        for (int i = 0; i < LLC_WAYS; i++) begin
            way_wr_en[i].coh  = wr_rst_flush[i] || way_hit[i];
            way_wr_en[i].data = way_hit[i];
        end
    end

    always_comb begin
        if (wr_en === 1'b1) begin
            way_known_a: assert (!$isunknown(way));
        end
    end

endmodule

`default_nettype wire

/* design/llc_way_store.sv */
`timescale 1ns/1ns
`default_nettype none

module llc_way_store
    import llc_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  llc_set_t   set_in,
    input  logic       rd_en,
    input  llc_wr_en_t wr_en,
    input  llc_coh_t   wr_coh,
    input  llc_data_t  wr_data,
    output llc_coh_t   rd_coh,
    output llc_data_t  rd_data
);

    llc_bank_t            bank;
    llc_bank_addr_t       bank_addr;
    llc_bank_t            rd_bank;
    logic [LLC_BANKS-1:0] coh_we;
    logic [LLC_BANKS-1:0] data_we;
    llc_coh_t             coh_q  [LLC_BANKS];
    llc_data_t            data_q [LLC_BANKS];

    // bank from the top set bits and row from the rest
    assign bank      = set_in[LLC_SET_BITS-1 -: LLC_BANK_BITS];
    assign bank_addr = set_in[LLC_BANK_ADDR_BITS-1:0];

    for (genvar b = 0; b < LLC_BANKS; b++) begin : g_bank
        assign coh_we[b]  = wr_en.coh && (bank == llc_bank_t'(b));
        assign data_we[b] = wr_en.data && (bank == llc_bank_t'(b));

        llc_bank_ram #(
            .WIDTH($bits(llc_coh_t)),
            .DEPTH(LLC_BANK_DEPTH)
        ) coh_ram (
            .clk  (clk),
            .rst  (rst),
            .addr (bank_addr),
            .en   (rd_en),
            .we   (coh_we[b]),
            .wdata(wr_coh),
            .rdata(coh_q[b])
        );

        llc_bank_ram #(
            .WIDTH($bits(llc_data_t)),
            .DEPTH(LLC_BANK_DEPTH)
        ) data_ram (
            .clk  (clk),
            .rst  (rst),
            .addr (bank_addr),
            .en   (rd_en),
            .we   (data_we[b]),
            .wdata(wr_data),
            .rdata(data_q[b])
        );
    end

    // bank of the last read, lines up with the ram output register
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_bank <= '0;
        end else if (rd_en) begin
            rd_bank <= bank;
        end
    end

    assign rd_coh  = coh_q[rd_bank];
    assign rd_data = data_q[rd_bank];

    // a write has to land in exactly one bank
    bank_known_a: assert property (@(posedge clk) disable iff (rst)
        (wr_en.coh || wr_en.data) |-> !$isunknown(bank));

endmodule

`default_nettype wire

/* design/llc_evict_store.sv */
`timescale 1ns/1ns
`default_nettype none

module llc_evict_store
    import llc_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  llc_set_t set_in,
    input  logic     rd_en,
    input  logic     wr_en_evict_way,
    input  llc_way_t wr_data_evict_way,
    output llc_way_t rd_evict_way
);

    llc_bank_t            bank;
    llc_bank_addr_t       bank_addr;
    llc_bank_t            rd_bank;
    logic [LLC_BANKS-1:0] evict_we;
    llc_way_t             evict_q [LLC_BANKS];

    assign bank      = set_in[LLC_SET_BITS-1 -: LLC_BANK_BITS];
    assign bank_addr = set_in[LLC_BANK_ADDR_BITS-1:0];

    // one pointer per set
    for (genvar b = 0; b < LLC_BANKS; b++) begin : g_bank
        assign evict_we[b] = wr_en_evict_way && (bank == llc_bank_t'(b));

        llc_bank_ram #(
            .WIDTH($bits(llc_way_t)),
            .DEPTH(LLC_BANK_DEPTH)
        ) evict_ram (
            .clk  (clk),
            .rst  (rst),
            .addr (bank_addr),
            .en   (rd_en),
            .we   (evict_we[b]),
            .wdata(wr_data_evict_way),
            .rdata(evict_q[b])
        );
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_bank <= '0;
        end else if (rd_en) begin
            rd_bank <= bank;
        end
    end

    assign rd_evict_way = evict_q[rd_bank];

endmodule

`default_nettype wire

/* design/llc_localmem.sv */
`timescale 1ns/1ns
`default_nettype none

module llc_localmem
    import llc_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  llc_set_t                  set_in,
    input  llc_way_t                  way,
    input  logic                      rd_en,
    input  logic                      wr_en,
    input  llc_coh_t                  wr_coh,
    input  llc_data_t                 wr_data,
    input  logic [LLC_WAYS-1:0]       wr_rst_flush,
    input  logic                      wr_en_evict_way,
    input  llc_way_t                  wr_data_evict_way,
    output llc_coh_t  [LLC_WAYS-1:0]  rd_coh,
    output llc_data_t [LLC_WAYS-1:0]  rd_data,
    output llc_way_t                  rd_evict_way
);

    llc_wr_en_t [LLC_WAYS-1:0] way_wr_en;

    llc_wr_ctrl wr_ctrl (
        .wr_en       (wr_en),
        .way         (way),
        .wr_rst_flush(wr_rst_flush),
        .way_wr_en   (way_wr_en)
    );

    // all ways see the same set and read strobe
    for (genvar w = 0; w < LLC_WAYS; w++) begin : g_way
        llc_way_store way_store (
            .clk    (clk),
            .rst    (rst),
            .set_in (set_in),
            .rd_en  (rd_en),
            .wr_en  (way_wr_en[w]),
            .wr_coh (wr_coh),
            .wr_data(wr_data),
            .rd_coh (rd_coh[w]),
            .rd_data(rd_data[w])
        );
    end

    llc_evict_store evict_store (
        .clk              (clk),
        .rst              (rst),
        .set_in           (set_in),
        .rd_en            (rd_en),
        .wr_en_evict_way  (wr_en_evict_way),
        .wr_data_evict_way(wr_data_evict_way),
        .rd_evict_way     (rd_evict_way)
    );

endmodule

`default_nettype wire

/* sim/tb_llc_localmem.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_llc_localmem
    import llc_pkg::*;
();

    localparam int CLK_PERIOD  = 40;
    localparam int RST_CYCLES  = 5;
    localparam int RST_TIMEOUT = 20;
    localparam int MAX_RECS    = 128;

    localparam logic [3:0] OP_END   = 4'h0;
    localparam logic [3:0] OP_WRITE = 4'h1;
    localparam logic [3:0] OP_FLUSH = 4'h2;
    localparam logic [3:0] OP_EVICT = 4'h3;
    localparam logic [3:0] OP_READ  = 4'h4;

    // one line of the data file, each column padded to whole hex digits
    typedef struct packed {
        logic [3:0]          op;
        logic                flag_pad;
        logic                chk_evict;
        logic                chk_way;
        logic                rd;
        logic [1:0]          set_pad;
        llc_set_t            set_idx;
        logic [1:0]          way_pad;
        llc_way_t            way;
        logic [LLC_WAYS-1:0] flush;
        llc_coh_t            coh;
        logic                data_pad;
        llc_data_t           data;
        logic [1:0]          evict_pad;
        llc_way_t            evict;
    } test_rec_t;

    logic                     clk;
    logic                     rst;
    llc_set_t                 set_in;
    llc_way_t                 way;
    logic                     rd_en;
    logic                     wr_en;
    llc_coh_t                 wr_coh;
    llc_data_t                wr_data;
    logic [LLC_WAYS-1:0]      wr_rst_flush;
    logic                     wr_en_evict_way;
    llc_way_t                 wr_data_evict_way;
    llc_coh_t  [LLC_WAYS-1:0] rd_coh;
    llc_data_t [LLC_WAYS-1:0] rd_data;
    llc_way_t                 rd_evict_way;

    logic [$bits(test_rec_t)-1:0] recs [MAX_RECS];
    int                           cur_rec;

    llc_localmem dut0 (
        .clk              (clk),
        .rst              (rst),
        .set_in           (set_in),
        .way              (way),
        .rd_en            (rd_en),
        .wr_en            (wr_en),
        .wr_coh           (wr_coh),
        .wr_data          (wr_data),
        .wr_rst_flush     (wr_rst_flush),
        .wr_en_evict_way  (wr_en_evict_way),
        .wr_data_evict_way(wr_data_evict_way),
        .rd_coh           (rd_coh),
        .rd_data          (rd_data),
        .rd_evict_way     (rd_evict_way)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // reset held over five rising edges, released on a falling edge
    initial begin
        rst = 1'b1;
        for (int i = 0; i < RST_CYCLES; i++) begin
            @(posedge clk);
        end
        @(negedge clk);
        rst = 1'b0;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic report_mismatch(input string msg);
        report_failure($sformatf("[ERROR] %0t ns: record %0d, %s", $time, cur_rec, msg));
    endtask

    task automatic check_coh(input llc_way_t w, input llc_coh_t got, input llc_coh_t exp);
        if (got !== exp) begin
            report_mismatch($sformatf(
                "way %0d coh got state %0h sharers %0h dirty %0b, expected %0h %0h %0b",
                w, got.state, got.sharers, got.dirty, exp.state, exp.sharers, exp.dirty));
        end
    endtask

    task automatic check_data(input llc_way_t w, input llc_data_t got, input llc_data_t exp);
        if (got !== exp) begin
            report_mismatch($sformatf(
                "way %0d data got tag %0h line %h, expected tag %0h line %h (full %h vs %h)",
                w, got.tag, got.line, exp.tag, exp.line, got, exp));
        end
    endtask

    task automatic check_evict(input llc_way_t got, input llc_way_t exp);
        if (got !== exp) begin
            report_mismatch($sformatf("evict way got %0d, expected %0d", got, exp));
        end
    endtask

    task automatic drive_idle();
        set_in            = '0;
        way               = '0;
        rd_en             = 1'b0;
        wr_en             = 1'b0;
        wr_coh            = '0;
        wr_data           = '0;
        wr_rst_flush      = '0;
        wr_en_evict_way   = 1'b0;
        wr_data_evict_way = '0;
    endtask

    task automatic drive_record(input test_rec_t rec);
        drive_idle();
        set_in = rec.set_idx;
        rd_en  = rec.rd;
        case (rec.op)
            OP_WRITE: begin
                wr_en   = 1'b1;
                way     = rec.way;
                wr_coh  = rec.coh;
                wr_data = rec.data;
            end
            OP_FLUSH: begin
                wr_rst_flush = rec.flush;
                wr_coh       = rec.coh;
            end
            OP_EVICT: begin
                wr_en_evict_way   = 1'b1;
                wr_data_evict_way = rec.evict;
            end
            OP_READ: begin
                way = rec.way;
            end
            default: begin
                report_failure($sformatf("record %0d has unknown opcode %0h", cur_rec, rec.op));
            end
        endcase
    endtask

    // outputs are registered, so they are settled by the falling edge
    task automatic check_record(input test_rec_t rec);
        if (rec.chk_way) begin
            check_coh(rec.way, rd_coh[rec.way], rec.coh);
            check_data(rec.way, rd_data[rec.way], rec.data);
        end
        if (rec.chk_evict) begin
            check_evict(rd_evict_way, rec.evict);
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (rst !== 1'b0) begin
            @(negedge clk);
            cycles++;
            if (cycles > RST_TIMEOUT) begin
                report_failure($sformatf("reset still high after %0d cycles", RST_TIMEOUT));
            end
        end
    endtask

    initial begin
        test_rec_t rec;
        int        n_checks;
        n_checks = 0;
        cur_rec  = 0;
        drive_idle();
        for (int i = 0; i < MAX_RECS; i++) begin
            recs[i] = '0;
        end
        $readmemh("sim/llc_testdata.txt", recs);

        wait_reset_release();

        for (int i = 0; i < MAX_RECS; i++) begin
            rec = recs[i];
            if (rec.op == OP_END) begin
                break;
            end
            cur_rec = i;
            drive_record(rec);
            @(negedge clk);
            if (rec.op == OP_READ) begin
                check_record(rec);
                n_checks++;
            end
        end
        drive_idle();

        if (n_checks == 0) begin
            report_failure("no read checks were found in sim/llc_testdata.txt");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* sim/llc_testdata.txt */
// op_flags_set_way_flush_coh_data_evict, data is {pad, tag, owner, hprot} then the 64-bit line
// op 1 write, 2 flush, 3 evict write, 4 read and check; flags bit0 rd_en,
// bit1 check coh/data of the way column, bit2 check evict; op 4 columns hold expected values

// outputs are cleared by reset
4_6_00_0_0_00_0000_0000000000000000_0

// all ways of set 05 (bank 0) and set 25 (bank 1)
1_0_05_0_0_11_1a01_05000000deadbe00_0
1_0_05_1_0_2a_2b02_05010000deadbe01_0
1_0_05_2_0_3c_3c03_05020000deadbe02_0
1_0_05_3_0_44_4d04_05030000deadbe03_0
1_0_25_0_0_91_6a11_25000000cafef000_0
1_0_25_1_0_a2_6b12_25010000cafef001_0
1_0_25_2_0_b3_6c13_25020000cafef002_0
1_0_25_3_0_c4_6d14_25030000cafef003_0
4_3_05_0_0_11_1a01_05000000deadbe00_0
4_2_05_1_0_2a_2b02_05010000deadbe01_0
4_2_05_2_0_3c_3c03_05020000deadbe02_0
4_2_05_3_0_44_4d04_05030000deadbe03_0
4_3_25_0_0_91_6a11_25000000cafef000_0
4_2_25_1_0_a2_6b12_25010000cafef001_0
4_2_25_2_0_b3_6c13_25020000cafef002_0
4_2_25_3_0_c4_6d14_25030000cafef003_0

// flush ways 1 and 2 of set 05, data part stays
2_0_05_0_6_07_0000_0000000000000000_0
4_3_05_0_0_11_1a01_05000000deadbe00_0
4_2_05_1_0_07_2b02_05010000deadbe01_0
4_2_05_2_0_07_3c03_05020000deadbe02_0
4_2_05_3_0_44_4d04_05030000deadbe03_0
4_3_25_1_0_a2_6b12_25010000cafef001_0
4_2_25_2_0_b3_6c13_25020000cafef002_0

// eviction pointers in both banks
3_0_05_0_0_00_0000_0000000000000000_2
3_0_25_0_0_00_0000_0000000000000000_1
3_0_10_0_0_00_0000_0000000000000000_3
3_0_3f_0_0_00_0000_0000000000000000_0
4_7_05_0_0_11_1a01_05000000deadbe00_2
4_5_25_0_0_00_0000_0000000000000000_1
4_5_10_0_0_00_0000_0000000000000000_3
4_5_3f_0_0_00_0000_0000000000000000_0
3_0_10_0_0_00_0000_0000000000000000_1
4_5_10_0_0_00_0000_0000000000000000_1

// read on the same edge as a write returns the old contents
1_1_25_3_0_e5_7e15_25030000beefbe03_0
4_2_25_3_0_c4_6d14_25030000cafef003_0
4_3_25_3_0_e5_7e15_25030000beefbe03_0
3_1_10_0_0_00_0000_0000000000000000_2
4_4_10_0_0_00_0000_0000000000000000_1
4_5_10_0_0_00_0000_0000000000000000_2

// outputs hold with rd_en low while the read set and others change
4_3_05_3_0_44_4d04_05030000deadbe03_0
1_0_05_3_0_5e_5e05_05030000feedf003_0
1_0_2a_0_0_f1_7f21_2a000000feedf000_0
3_0_05_0_0_00_0000_0000000000000000_3
2_0_05_0_1_00_0000_0000000000000000_0
4_6_05_3_0_44_4d04_05030000deadbe03_2
4_7_05_3_0_5e_5e05_05030000feedf003_3
4_2_05_0_0_00_1a01_05000000deadbe00_0
4_3_2a_0_0_f1_7f21_2a000000feedf000_0

/* src.f */
design/llc_pkg.sv
design/llc_bank_ram.sv
design/llc_wr_ctrl.sv
design/llc_way_store.sv
design/llc_evict_store.sv
design/llc_localmem.sv
sim/tb_llc_localmem.sv

/* Makefile */
# Verilator simulation of the LLC local memory

VERILATOR ?= verilator
TOP       ?= tb_llc_localmem
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns
PASS_MSG  ?= Test OK

.PHONY: sim clean

# the run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
